// ==== common/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// one cached block is DC_DEPTH words of DC_WIDTH bits.
// column access needs both to be equal.
`define DC_DEPTH 16
`define DC_WIDTH 16
`define DC_IDX_W 4

// processor word address and the block number inside it.
`define DC_MEM_AW 16
`define DC_BLK_W (`DC_MEM_AW - `DC_IDX_W)

// DDR is byte addressed with 8 bytes per word slot.
`define DC_DDR_AW 28
`define DC_DDR_SCALE 8

`define DC_CTXT_BASE 16'h5000
`define DC_CTXT_STEP (3 * `DC_DEPTH)

`endif

// ==== common/dcache_pkg.sv ====
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

    typedef enum logic [2:0] {
        ROW_LOAD  = 3'd1,
        ROW_STORE = 3'd2,
        COL_LOAD  = 3'd3,
        COL_STORE = 3'd4,
        FLUSH     = 3'd5
    } dc_op_e;

    typedef struct packed {
        logic [`DC_BLK_W-1:0] block;
        logic [`DC_IDX_W-1:0] word;
    } dc_row_addr_s;

    typedef struct packed {
        logic [`DC_BLK_W-1:0] block;
        logic [`DC_IDX_W-1:0] col;
    } dc_col_sel_s;

    // the operand names a word for row ops and a bit position for column ops.
    typedef union packed {
        dc_row_addr_s row;
        dc_col_sel_s  col;
    } dc_operand_u;

    typedef struct packed {
        dc_op_e                op;
        dc_operand_u           operand;
        logic [`DC_WIDTH-1:0]  wdata;
    } dc_cmd_s;

    typedef struct packed {
        logic                  valid;
        dc_op_e                op;
        logic                  is_col;
        logic                  is_wr;
        logic [`DC_BLK_W-1:0]  block;
        logic [`DC_IDX_W-1:0]  index;
        logic [`DC_WIDTH-1:0]  wdata;
    } dc_dec_s;

    typedef struct packed {
        logic                  valid;
        logic [`DC_WIDTH-1:0]  rdata;
    } dc_rsp_s;

endpackage

`default_nettype wire

// ==== data_cache/data_cache_array.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module data_cache_array
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 row_we,
    input  logic                 col_we,
    input  logic                 fill_we,
    input  logic [`DC_IDX_W-1:0] index,
    input  logic [`DC_WIDTH-1:0] wdata,
    output logic [`DC_WIDTH-1:0] row_rdata,
    output logic [`DC_WIDTH-1:0] col_rdata
);

    logic [`DC_WIDTH-1:0] mem [`DC_DEPTH];

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int w = 0; w < `DC_DEPTH; w++)
                mem[w] <= '0;
        end
        else if (fill_we || row_we)
        begin
            mem[index] <= wdata;
        end
        else if (col_we)
        begin
            // word w takes bit w of the column vector at bit position index.
            for (int w = 0; w < `DC_DEPTH; w++)
                mem[w][index] <= wdata[w];
        end
    end

    assign row_rdata = mem[index];

    always_comb
    begin
        for (int w = 0; w < `DC_DEPTH; w++)
            col_rdata[w] = mem[w][index];
    end

endmodule

`default_nettype wire

// ==== data_cache/data_cache_ctrl.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module data_cache_ctrl
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  dc_dec_s               dec,
    output logic                  idle,
    output logic                  arr_row_we,
    output logic                  arr_col_we,
    output logic                  arr_fill_we,
    output logic [`DC_IDX_W-1:0]  arr_index,
    output logic [`DC_WIDTH-1:0]  arr_wdata,
    output logic                  done,
    output logic                  done_col,
    output logic                  ddr_rd_req,
    output logic                  ddr_wr_req,
    output logic [`DC_DDR_AW-1:0] ddr_rd_addr,
    output logic [`DC_DDR_AW-1:0] ddr_wr_addr,
    input  logic                  ddr_rd_valid,
    input  logic                  ddr_wr_ready,
    input  logic [`DC_WIDTH-1:0]  ddr_rd_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_WB,
        S_FILL
    } state_e;

    state_e               state;
    state_e               state_nx;
    logic [`DC_IDX_W-1:0] cnt;
    logic [`DC_BLK_W-1:0] tag_q;
    logic                 valid_q;
    logic                 dirty_q;

    logic start;
    logic is_flush;
    logic hit;
    logic act;
    logic flush_done;
    logic wb_last;
    logic fill_last;

    function automatic logic [`DC_DDR_AW-1:0] ddr_addr(input logic [`DC_BLK_W-1:0] blk);
        logic [`DC_DDR_AW-1:0] word_addr;
        word_addr = `DC_DDR_AW'({blk, {`DC_IDX_W{1'b0}}});
        return word_addr * `DC_DDR_SCALE;
    endfunction

    assign start    = (state == S_IDLE) && dec.valid;
    assign is_flush = (dec.op == FLUSH);
    assign hit      = valid_q && (tag_q == dec.block);

    // a hit runs straight from idle; a miss comes back through execute.
    assign act        = !is_flush && ((start && hit) || (state == S_EXEC));
    assign flush_done = is_flush && ((start && !(valid_q && dirty_q)) || (state == S_EXEC));

    assign wb_last   = (state == S_WB) && ddr_wr_ready
                       && (cnt == `DC_IDX_W'(`DC_DEPTH - 1));
    assign fill_last = (state == S_FILL) && ddr_rd_valid
                       && (cnt == `DC_IDX_W'(`DC_DEPTH - 1));

    always_comb
    begin
        state_nx = state;
        case (state)
            S_IDLE:
            begin
                if (start)
                begin
                    if (is_flush)
                    begin
                        if (valid_q && dirty_q)
                            state_nx = S_WB;
                    end
                    else if (!hit)
                    begin
                        state_nx = (valid_q && dirty_q) ? S_WB : S_FILL;
                    end
                end
            end
            S_EXEC:
                state_nx = S_IDLE;
            S_WB:
            begin
                if (wb_last)
                    state_nx = is_flush ? S_EXEC : S_FILL;
            end
            S_FILL:
            begin
                if (fill_last)
                    state_nx = S_EXEC;
            end
            default:
                state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state   <= S_IDLE;
            cnt     <= '0;
            tag_q   <= '0;
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end
        else
        begin
            state <= state_nx;
            // bursts are always DC_DEPTH words, so the counter wraps back to zero.
            if (((state == S_WB) && ddr_wr_ready) || ((state == S_FILL) && ddr_rd_valid))
                cnt <= cnt + 1'b1;
            if (wb_last)
                dirty_q <= 1'b0;
            if (fill_last)
            begin
                tag_q   <= dec.block;
                valid_q <= 1'b1;
                dirty_q <= 1'b0;
            end
            if (act && dec.is_wr)
                dirty_q <= 1'b1;
        end
    end

    assign idle        = (state == S_IDLE) && !dec.valid;
    assign done        = act || flush_done;
    assign done_col    = dec.is_col;
    assign arr_row_we  = act && dec.is_wr && !dec.is_col;
    assign arr_col_we  = act && dec.is_wr && dec.is_col;
    assign arr_fill_we = (state == S_FILL) && ddr_rd_valid;
    assign arr_index   = ((state == S_WB) || (state == S_FILL)) ? cnt : dec.index;
    assign arr_wdata   = (state == S_FILL) ? ddr_rd_data : dec.wdata;

    assign ddr_rd_req  = (state == S_FILL);
    assign ddr_wr_req  = (state == S_WB);
    assign ddr_rd_addr = ddr_addr(dec.block);
    assign ddr_wr_addr = ddr_addr(tag_q);

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/dcache_pkg.sv
source/dcache_cmd_decode.sv
data_cache/data_cache_ctrl.sv
data_cache/data_cache_array.sv
source/dcache_response.sv
source/dcache_top.sv
verification/clock_gen.sv
verification/ddr_model.sv
verification/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module dcache_tb -o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

// ==== source/dcache_cmd_decode.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module dcache_cmd_decode
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cmd_req,
    input  dc_cmd_s cmd,
    output dc_dec_s dec
);

    logic                 dec_valid;
    dc_op_e               dec_op;
    logic                 dec_is_col;
    logic                 dec_is_wr;
    logic [`DC_BLK_W-1:0] dec_block;
    logic [`DC_IDX_W-1:0] dec_index;
    logic [`DC_WIDTH-1:0] dec_wdata;
    logic                 col_op;

    assign col_op = (cmd.op == COL_LOAD) || (cmd.op == COL_STORE);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            dec_valid <= 1'b0;
        else
            dec_valid <= cmd_req;
    end

    // the fields stay put until the next command, so the execute stage
    // can still use them after a fill.
    always_ff @(posedge clk)
    begin
        if (cmd_req)
        begin
            dec_op     <= cmd.op;
            dec_is_col <= col_op;
            dec_is_wr  <= (cmd.op == ROW_STORE) || (cmd.op == COL_STORE);
            dec_wdata  <= cmd.wdata;
            // the column view keeps the block number and the bit index at the same bits.
            dec_block  <= cmd.operand.row.block;
            dec_index  <= cmd.operand.row.word;
        end
    end

    assign dec = '{valid: dec_valid, op: dec_op, is_col: dec_is_col, is_wr: dec_is_wr,
                   block: dec_block, index: dec_index, wdata: dec_wdata};

endmodule

`default_nettype wire

// ==== source/dcache_response.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module dcache_response
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  done,
    input  logic                  done_col,
    input  logic [`DC_WIDTH-1:0]  row_rdata,
    input  logic [`DC_WIDTH-1:0]  col_rdata,
    input  logic                  ctxt_done,
    output dc_rsp_s               rsp,
    output logic [`DC_MEM_AW-1:0] ctxt_addr
);

    logic                 rsp_valid;
    logic [`DC_WIDTH-1:0] rsp_rdata;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= done;
    end

    always_ff @(posedge clk)
    begin
        if (done)
            rsp_rdata <= done_col ? col_rdata : row_rdata;
    end

    assign rsp.valid = rsp_valid;
    assign rsp.rdata = rsp_rdata;

    // each saved context takes three blocks.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            ctxt_addr <= `DC_MEM_AW'(`DC_CTXT_BASE);
        else if (ctxt_done)
            ctxt_addr <= ctxt_addr + `DC_MEM_AW'(`DC_CTXT_STEP);
    end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_req,
    input  dc_cmd_s               cmd,
    output logic                  idle,
    output dc_rsp_s               rsp,
    input  logic                  ctxt_done,
    output logic [`DC_MEM_AW-1:0] ctxt_addr,
    output logic                  ddr_rd_req,
    output logic [`DC_DDR_AW-1:0] ddr_rd_addr,
    input  logic                  ddr_rd_valid,
    input  logic [`DC_WIDTH-1:0]  ddr_rd_data,
    output logic                  ddr_wr_req,
    output logic [`DC_DDR_AW-1:0] ddr_wr_addr,
    input  logic                  ddr_wr_ready,
    output logic [`DC_WIDTH-1:0]  ddr_wr_data
);

    dc_dec_s              dec;
    logic                 arr_row_we;
    logic                 arr_col_we;
    logic                 arr_fill_we;
    logic [`DC_IDX_W-1:0] arr_index;
    logic [`DC_WIDTH-1:0] arr_wdata;
    logic [`DC_WIDTH-1:0] arr_row_rdata;
    logic [`DC_WIDTH-1:0] arr_col_rdata;
    logic                 done;
    logic                 done_col;
    logic                 load_op;

    // only loads return data; stores and flushes answer with zero.
    assign load_op     = !dec.is_wr && (dec.op != FLUSH);
    assign ddr_wr_data = arr_row_rdata;

    dcache_cmd_decode dcache_cmd_decode_inst (
        .clk     (clk),
        .rst     (rst),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .dec     (dec)
    );

    data_cache_ctrl data_cache_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .dec          (dec),
        .idle         (idle),
        .arr_row_we   (arr_row_we),
        .arr_col_we   (arr_col_we),
        .arr_fill_we  (arr_fill_we),
        .arr_index    (arr_index),
        .arr_wdata    (arr_wdata),
        .done         (done),
        .done_col     (done_col),
        .ddr_rd_req   (ddr_rd_req),
        .ddr_wr_req   (ddr_wr_req),
        .ddr_rd_addr  (ddr_rd_addr),
        .ddr_wr_addr  (ddr_wr_addr),
        .ddr_rd_valid (ddr_rd_valid),
        .ddr_wr_ready (ddr_wr_ready),
        .ddr_rd_data  (ddr_rd_data)
    );

    data_cache_array data_cache_array_inst (
        .clk       (clk),
        .rst       (rst),
        .row_we    (arr_row_we),
        .col_we    (arr_col_we),
        .fill_we   (arr_fill_we),
        .index     (arr_index),
        .wdata     (arr_wdata),
        .row_rdata (arr_row_rdata),
        .col_rdata (arr_col_rdata)
    );

    dcache_response dcache_response_inst (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .done_col  (done_col),
        .row_rdata (load_op ? arr_row_rdata : '0),
        .col_rdata (load_op ? arr_col_rdata : '0),
        .ctxt_done (ctxt_done),
        .rsp       (rsp),
        .ctxt_addr (ctxt_addr)
    );

endmodule

`default_nettype wire

// ==== verification/clock_gen.sv ====
`default_nettype none

module clock_gen
(
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    // reset is released just after the tenth rising edge.
    initial
    begin
        rst = 1'b0;
        repeat (10)
            @(posedge clk);
        #1;
        rst = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/dcache_tb.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module dcache_tb
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // lat stays zero when DDR traffic decides the latency.
    typedef struct packed {
        dc_op_e               op;
        logic [`DC_BLK_W-1:0] block;
        logic [`DC_IDX_W-1:0] index;
        logic [`DC_WIDTH-1:0] wdata;
        logic [`DC_WIDTH-1:0] rdata;
        logic [3:0]           lat;
        logic                 rd;
        logic                 wb;
    } step_s;

    logic                  clk;
    logic                  rst;
    logic                  cmd_req;
    dc_cmd_s               cmd;
    logic                  idle;
    dc_rsp_s               rsp;
    logic                  ctxt_done;
    logic [`DC_MEM_AW-1:0] ctxt_addr;
    logic                  ddr_rd_req;
    logic [`DC_DDR_AW-1:0] ddr_rd_addr;
    logic                  ddr_rd_valid;
    logic [`DC_WIDTH-1:0]  ddr_rd_data;
    logic                  ddr_wr_req;
    logic [`DC_DDR_AW-1:0] ddr_wr_addr;
    logic                  ddr_wr_ready;
    logic [`DC_WIDTH-1:0]  ddr_wr_data;

    step_s                steps[$];
    logic [`DC_WIDTH-1:0] shadow [0:65535];
    logic [`DC_BLK_W-1:0] sh_tag;
    logic                 sh_valid;
    logic                 sh_dirty;
    int                   cycle = 0;
    int                   limit = 0;
    int                   checks = 0;
    int                   errors = 0;

    clock_gen clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    ddr_model ddr_model_inst (
        .clk      (clk),
        .rd_req   (ddr_rd_req),
        .rd_addr  (ddr_rd_addr),
        .rd_valid (ddr_rd_valid),
        .rd_data  (ddr_rd_data),
        .wr_req   (ddr_wr_req),
        .wr_addr  (ddr_wr_addr),
        .wr_ready (ddr_wr_ready),
        .wr_data  (ddr_wr_data)
    );

    dcache_top dcache_top_inst (
        .clk          (clk),
        .rst          (rst),
        .cmd_req      (cmd_req),
        .cmd          (cmd),
        .idle         (idle),
        .rsp          (rsp),
        .ctxt_done    (ctxt_done),
        .ctxt_addr    (ctxt_addr),
        .ddr_rd_req   (ddr_rd_req),
        .ddr_rd_addr  (ddr_rd_addr),
        .ddr_rd_valid (ddr_rd_valid),
        .ddr_rd_data  (ddr_rd_data),
        .ddr_wr_req   (ddr_wr_req),
        .ddr_wr_addr  (ddr_wr_addr),
        .ddr_wr_ready (ddr_wr_ready),
        .ddr_wr_data  (ddr_wr_data)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // the shadow keeps the memory as the processor sees it, plus the
    // tag, valid and dirty state that decide fills and write-backs.
    task automatic add_step(input dc_op_e op, input logic [`DC_BLK_W-1:0] blk,
                            input logic [`DC_IDX_W-1:0] idx, input logic [`DC_WIDTH-1:0] wdata);
        step_s s;
        logic  hit;
        hit     = sh_valid && (sh_tag == blk);
        s.op    = op;
        s.block = blk;
        s.index = idx;
        s.wdata = wdata;
        s.rdata = '0;
        s.rd    = 1'b0;
        s.wb    = sh_valid && sh_dirty && ((op == FLUSH) || !hit);
        s.lat   = 4'd0;
        if (op == FLUSH)
        begin
            if (!s.wb)
                s.lat = 4'd2;
            sh_dirty = 1'b0;
        end
        else
        begin
            if (hit)
            begin
                s.lat = 4'd2;
            end
            else
            begin
                s.rd     = 1'b1;
                sh_tag   = blk;
                sh_valid = 1'b1;
                sh_dirty = 1'b0;
            end
            case (op)
                ROW_LOAD:
                    s.rdata = shadow[{blk, idx}];
                ROW_STORE:
                    shadow[{blk, idx}] = wdata;
                COL_LOAD:
                    for (int w = 0; w < `DC_DEPTH; w++)
                        s.rdata[w] = shadow[{blk, 4'(w)}][idx];
                COL_STORE:
                    for (int w = 0; w < `DC_DEPTH; w++)
                        shadow[{blk, 4'(w)}][idx] = wdata[w];
                default:
                    s.rdata = '0;
            endcase
            if ((op == ROW_STORE) || (op == COL_STORE))
                sh_dirty = 1'b1;
        end
        steps.push_back(s);
    endtask

    task automatic build_table();
        // block 123 is filled, then read and written in both views.
        add_step(ROW_LOAD,  12'h123, 4'd3,  '0);
        add_step(ROW_LOAD,  12'h123, 4'd9,  '0);
        add_step(ROW_STORE, 12'h123, 4'd5,  16'h1234);
        add_step(COL_LOAD,  12'h123, 4'd2,  '0);
        add_step(COL_STORE, 12'h123, 4'd7,  16'hb00f);
        add_step(ROW_LOAD,  12'h123, 4'd0,  '0);
        add_step(ROW_LOAD,  12'h123, 4'd5,  '0);
        add_step(ROW_LOAD,  12'h123, 4'd15, '0);
        add_step(COL_LOAD,  12'h123, 4'd7,  '0);
        // dirty evictions back and forth between two blocks.
        add_step(ROW_LOAD,  12'h7a0, 4'd4,  '0);
        add_step(ROW_STORE, 12'h7a0, 4'd4,  16'hcafe);
        add_step(ROW_LOAD,  12'h123, 4'd5,  '0);
        add_step(COL_LOAD,  12'h123, 4'd7,  '0);
        add_step(ROW_LOAD,  12'h7a0, 4'd4,  '0);
        add_step(COL_STORE, 12'h7a0, 4'd1,  16'h0f0f);
        // the second flush finds the block clean.
        add_step(FLUSH,     12'h7a0, 4'd0,  '0);
        add_step(FLUSH,     12'h7a0, 4'd0,  '0);
        add_step(ROW_LOAD,  12'h0ff, 4'd2,  '0);
        add_step(COL_LOAD,  12'h7a0, 4'd1,  '0);
    endtask

    task automatic run_step(input step_s s);
        int   start;
        logic rd_seen;
        logic wr_seen;
        while (idle !== 1'b1)
            @(negedge clk);
        @(posedge clk);
        #1;
        cmd.op    = s.op;
        cmd.wdata = s.wdata;
        if ((s.op == COL_LOAD) || (s.op == COL_STORE))
        begin
            cmd.operand.col.block = s.block;
            cmd.operand.col.col   = s.index;
        end
        else
        begin
            cmd.operand.row.block = s.block;
            cmd.operand.row.word  = s.index;
        end
        cmd_req = 1'b1;
        start   = cycle;
        rd_seen = 1'b0;
        wr_seen = 1'b0;
        @(posedge clk);
        #1;
        cmd_req = 1'b0;
        @(negedge clk);
        check_value("idle", idle, 0);
        while (rsp.valid !== 1'b1)
        begin
            rd_seen |= ddr_rd_req;
            wr_seen |= ddr_wr_req;
            @(negedge clk);
        end
        check_value("rsp.rdata", rsp.rdata, s.rdata);
        check_value("idle", idle, 1);
        if (s.lat != 0)
            check_value("latency", cycle - start, s.lat);
        check_value("ddr_rd_req", rd_seen, s.rd);
        check_value("ddr_wr_req", wr_seen, s.wb);
        @(negedge clk);
        check_value("rsp.valid", rsp.valid, 0);
    endtask

    // the limit allows every step a dirty miss with the slowest DDR.
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle > limit)
        begin
            $display("timeout: the cache did not answer within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        cmd_req   = 1'b0;
        cmd       = '0;
        ctxt_done = 1'b0;
        for (int a = 0; a < 65536; a++)
            shadow[a] = 16'(a) ^ 16'ha5c3;
        sh_tag   = '0;
        sh_valid = 1'b0;
        sh_dirty = 1'b0;
        build_table();
        limit = steps.size() * (4 * `DC_DEPTH * 3 + 10) + 20;

        while (rst !== 1'b1)
            @(negedge clk);
        @(negedge clk);
        check_value("idle", idle, 1);
        check_value("ctxt_addr", ctxt_addr, `DC_CTXT_BASE);
        check_value("ddr_rd_req", ddr_rd_req, 0);
        check_value("ddr_wr_req", ddr_wr_req, 0);
        check_value("rsp.valid", rsp.valid, 0);

        foreach (steps[i])
            run_step(steps[i]);

        // the context address moves one cycle after each strobe.
        for (int n = 1; n <= 3; n++)
        begin
            @(posedge clk);
            #1;
            ctxt_done = 1'b1;
            @(negedge clk);
            check_value("ctxt_addr", ctxt_addr,
                        16'(`DC_CTXT_BASE + (n - 1) * `DC_CTXT_STEP));
            @(posedge clk);
            #1;
            ctxt_done = 1'b0;
            @(negedge clk);
            check_value("ctxt_addr", ctxt_addr, 16'(`DC_CTXT_BASE + n * `DC_CTXT_STEP));
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/ddr_model.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module ddr_model
(
    input  logic                  clk,
    input  logic                  rd_req,
    input  logic [`DC_DDR_AW-1:0] rd_addr,
    output logic                  rd_valid,
    output logic [`DC_WIDTH-1:0]  rd_data,
    input  logic                  wr_req,
    input  logic [`DC_DDR_AW-1:0] wr_addr,
    output logic                  wr_ready,
    input  logic [`DC_WIDTH-1:0]  wr_data
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`DC_WIDTH-1:0] mem [0:65535];
    int                   rd_idx;
    int                   wr_idx;
    int                   gap;

    function automatic logic [15:0] word_of(input logic [`DC_DDR_AW-1:0] addr, input int i);
        return 16'(addr / `DC_DDR_SCALE) + 16'(i);
    endfunction

    initial
    begin
        for (int a = 0; a < 65536; a++)
            mem[a] = 16'(a) ^ 16'ha5c3;
        rd_valid = 1'b0;
        rd_data  = '0;
        wr_ready = 1'b0;
        rd_idx   = 0;
        wr_idx   = 0;
        gap      = $urandom(32'hb244) % 3;
        forever
        begin
            @(posedge clk);
            #1;
            rd_valid = 1'b0;
            wr_ready = 1'b0;
            if (!rd_req)
                rd_idx = 0;
            if (!wr_req)
                wr_idx = 0;
            // a burst ends after DC_DEPTH words, whatever the request does next.
            if ((rd_req && rd_idx < `DC_DEPTH) || (wr_req && wr_idx < `DC_DEPTH))
            begin
                if (gap > 0)
                begin
                    gap--;
                end
                else if (rd_req)
                begin
                    rd_valid = 1'b1;
                    rd_data  = mem[word_of(rd_addr, rd_idx)];
                    rd_idx++;
                    gap = $urandom % 3;
                end
                else
                begin
                    // the word on wr_data is the one the cache gives up at the next edge.
                    wr_ready = 1'b1;
                    mem[word_of(wr_addr, wr_idx)] = wr_data;
                    wr_idx++;
                    gap = $urandom % 3;
                end
            end
        end
    end

endmodule

`default_nettype wire
